// ==== ctrl_consts.svh ====
`ifndef CTRL_CONSTS_SVH
`define CTRL_CONSTS_SVH

// effect knob ADC value width
`define CTRL_KNOB_W 10

// patch routing source code width
`define CTRL_SRC_W 3

// registers in the knob domain crossing
`define CTRL_SYNC_STAGES 2

// seven segment digits, one nibble each
`define CTRL_DIGITS 8

// finished memory request counter
`define CTRL_CNT_W 24

`endif

// ==== display_page_mux.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ctrl_consts.svh"

module display_page_mux (
    input  logic                    i_clk_dram_ctrl,
    input  logic                    i_rst_dram_ctrl,
    input  display_pkg::page_t      i_page,
    input  knob_pkg::knob_bundle_t  i_knobs,
    input  knob_pkg::patch_route_t  i_route,
    input  logic [`CTRL_CNT_W-1:0]  i_complete_count,
    output display_pkg::disp_word_t o_disp_word
);

    display_pkg::disp_word_t word_d;

    always_comb begin
        word_d = '0; // pads and gaps stay zero
        case (i_page)
            display_pkg::PAGE_COUNT: begin
                word_d.raw = {16'h0000, i_complete_count[15:0]};
            end
            display_pkg::PAGE_VOL_PITCH: begin
                word_d.pair.upper = i_knobs.volume;
                word_d.pair.lower = i_knobs.pitch;
            end
            display_pkg::PAGE_DELAY: begin
                word_d.pair.upper = i_knobs.delay_wet;
                word_d.pair.lower = i_knobs.delay_rate;
            end
            display_pkg::PAGE_DELAY_REVERB: begin
                word_d.pair.upper = i_knobs.delay_feedback;
                word_d.pair.lower = i_knobs.reverb_wet;
            end
            display_pkg::PAGE_REVERB: begin
                word_d.pair.upper = i_knobs.reverb_size;
                word_d.pair.lower = i_knobs.reverb_feedback;
            end
            display_pkg::PAGE_FILTER: begin
                word_d.pair.upper = i_knobs.filter_quality;
                word_d.pair.lower = i_knobs.filter_cutoff;
            end
            display_pkg::PAGE_DRIVE_CRUSH: begin
                word_d.pair.upper = i_knobs.distortion_drive;
                word_d.pair.lower = i_knobs.crush_pressure;
            end
            default: begin // routing page
                word_d.route.delay_src      = i_route.delay_src;
                word_d.route.reverb_src     = i_route.reverb_src;
                word_d.route.filter_src     = i_route.filter_src;
                word_d.route.distortion_src = i_route.distortion_src;
                word_d.route.crush_src      = i_route.crush_src;
                word_d.route.output_src     = i_route.output_src;
            end
        endcase
    end

    always_ff @(posedge i_clk_dram_ctrl) begin
        if (i_rst_dram_ctrl) begin
            o_disp_word <= '0;
        end else begin
            o_disp_word <= word_d;
        end
    end

endmodule

`default_nettype wire

// ==== display_pkg.sv ====
`include "ctrl_consts.svh"

package display_pkg;

    typedef enum logic [2:0] {
        PAGE_COUNT        = 3'd0, // low half of completion count
        PAGE_VOL_PITCH    = 3'd1,
        PAGE_DELAY        = 3'd2,
        PAGE_DELAY_REVERB = 3'd3,
        PAGE_REVERB       = 3'd4,
        PAGE_FILTER       = 3'd5,
        PAGE_DRIVE_CRUSH  = 3'd6,
        PAGE_ROUTING      = 3'd7
    } page_t;

    // two knobs, each right aligned in a 16 bit half
    typedef struct packed {
        logic [15-`CTRL_KNOB_W:0] pad_hi;
        logic [`CTRL_KNOB_W-1:0]  upper;
        logic [15-`CTRL_KNOB_W:0] pad_lo;
        logic [`CTRL_KNOB_W-1:0]  lower;
    } knob_pair_t;

    // one source per hex digit, output source on digit 0
    typedef struct packed {
        logic [31-6*`CTRL_SRC_W-5:0] pad;
        logic [`CTRL_SRC_W-1:0]      delay_src;
        logic                        gap4;
        logic [`CTRL_SRC_W-1:0]      reverb_src;
        logic                        gap3;
        logic [`CTRL_SRC_W-1:0]      filter_src;
        logic                        gap2;
        logic [`CTRL_SRC_W-1:0]      distortion_src;
        logic                        gap1;
        logic [`CTRL_SRC_W-1:0]      crush_src;
        logic                        gap0;
        logic [`CTRL_SRC_W-1:0]      output_src;
    } route_word_t;

    typedef union packed {
        knob_pair_t  pair;
        route_word_t route;
        logic [31:0] raw; // as the scanner sees it, eight nibbles
    } disp_word_t;

    typedef logic [6:0] seg_t; // active low, a in bit 0

endpackage

// ==== dram_status_display.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ctrl_consts.svh"

module dram_status_display #(
    parameter int SCAN_CYCLES = 1024
) (
    input  logic                    i_clk_dram_ctrl,
    input  logic                    i_rst_dram_ctrl,
    input  knob_pkg::knob_bundle_t  i_knobs,     // knob-reading domain
    input  knob_pkg::patch_route_t  i_route,     // knob-reading domain
    input  display_pkg::page_t      i_page,
    input  logic                    i_mem_complete,
    input  logic                    i_write_last,
    output display_pkg::seg_t       o_seg_cathode,
    output logic [`CTRL_DIGITS-1:0] o_seg_anode,
    output logic                    o_write_seen
);

    knob_pkg::knob_bundle_t   knobs_sync;
    knob_pkg::patch_route_t   route_sync;
    logic [`CTRL_CNT_W-1:0]   complete_count;
    display_pkg::disp_word_t  disp_word;

    knob_sync knob_sync_i (
        .i_clk_dram_ctrl (i_clk_dram_ctrl),
        .i_knobs         (i_knobs),
        .i_route         (i_route),
        .o_knobs         (knobs_sync),
        .o_route         (route_sync)
    );

    mem_activity_monitor mem_activity_monitor_i (
        .i_clk_dram_ctrl  (i_clk_dram_ctrl),
        .i_rst_dram_ctrl  (i_rst_dram_ctrl),
        .i_mem_complete   (i_mem_complete),
        .i_write_last     (i_write_last),
        .o_complete_count (complete_count),
        .o_write_seen     (o_write_seen)
    );

    display_page_mux display_page_mux_i (
        .i_clk_dram_ctrl  (i_clk_dram_ctrl),
        .i_rst_dram_ctrl  (i_rst_dram_ctrl),
        .i_page           (i_page),
        .i_knobs          (knobs_sync),
        .i_route          (route_sync),
        .i_complete_count (complete_count),
        .o_disp_word      (disp_word)
    );

    // one cathode bus shared by all eight digits
    seven_seg_scanner #(
        .SCAN_CYCLES (SCAN_CYCLES)
    ) seven_seg_scanner_i (
        .i_clk_dram_ctrl (i_clk_dram_ctrl),
        .i_rst_dram_ctrl (i_rst_dram_ctrl),
        .i_disp_word     (disp_word),
        .o_cathode       (o_seg_cathode),
        .o_anode         (o_seg_anode)
    );

endmodule

`default_nettype wire

// ==== knob_pkg.sv ====
`include "ctrl_consts.svh"

package knob_pkg;

    // all twelve effect knobs, volume in the top bits
    typedef struct packed {
        logic [`CTRL_KNOB_W-1:0] volume;
        logic [`CTRL_KNOB_W-1:0] pitch;
        logic [`CTRL_KNOB_W-1:0] delay_wet;
        logic [`CTRL_KNOB_W-1:0] delay_rate;
        logic [`CTRL_KNOB_W-1:0] delay_feedback;
        logic [`CTRL_KNOB_W-1:0] reverb_wet;
        logic [`CTRL_KNOB_W-1:0] reverb_size;
        logic [`CTRL_KNOB_W-1:0] reverb_feedback;
        logic [`CTRL_KNOB_W-1:0] filter_quality;
        logic [`CTRL_KNOB_W-1:0] filter_cutoff;
        logic [`CTRL_KNOB_W-1:0] distortion_drive;
        logic [`CTRL_KNOB_W-1:0] crush_pressure;
    } knob_bundle_t;

    // source feeding each effect input, from the patch pins
    typedef struct packed {
        logic [`CTRL_SRC_W-1:0] delay_src;
        logic [`CTRL_SRC_W-1:0] reverb_src;
        logic [`CTRL_SRC_W-1:0] filter_src;
        logic [`CTRL_SRC_W-1:0] distortion_src;
        logic [`CTRL_SRC_W-1:0] crush_src;
        logic [`CTRL_SRC_W-1:0] output_src;
    } patch_route_t;

endpackage

// ==== knob_sync.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ctrl_consts.svh"

module knob_sync (
    input  logic                    i_clk_dram_ctrl,
    input  knob_pkg::knob_bundle_t  i_knobs,
    input  knob_pkg::patch_route_t  i_route,
    output knob_pkg::knob_bundle_t  o_knobs,
    output knob_pkg::patch_route_t  o_route
);

    // knobs and routing cross together as one word
    typedef struct packed {
        knob_pkg::knob_bundle_t knobs;
        knob_pkg::patch_route_t route;
    } ctrl_word_t;

    ctrl_word_t sync_q [`CTRL_SYNC_STAGES];
    ctrl_word_t capture;

    assign capture.knobs = i_knobs;
    assign capture.route = i_route;

    // plain register chain, the knob values settle slowly
    always_ff @(posedge i_clk_dram_ctrl) begin
        sync_q[0] <= capture; // first stage may go metastable
        for (int s = 1; s < `CTRL_SYNC_STAGES; s++) begin
            sync_q[s] <= sync_q[s-1];
        end
    end

    assign o_knobs = sync_q[`CTRL_SYNC_STAGES-1].knobs;
    assign o_route = sync_q[`CTRL_SYNC_STAGES-1].route;

endmodule

`default_nettype wire

// ==== mem_activity_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ctrl_consts.svh"

module mem_activity_monitor (
    input  logic                   i_clk_dram_ctrl,
    input  logic                   i_rst_dram_ctrl,
    input  logic                   i_mem_complete,
    input  logic                   i_write_last,
    output logic [`CTRL_CNT_W-1:0] o_complete_count,
    output logic                   o_write_seen
);

    // one step per finished request and wraps at full width
    always_ff @(posedge i_clk_dram_ctrl) begin
        if (i_rst_dram_ctrl) begin
            o_complete_count <= '0;
        end else if (i_mem_complete) begin
            o_complete_count <= o_complete_count + 1'b1;
        end
    end

    // held high from the first write burst until reset
    always_ff @(posedge i_clk_dram_ctrl) begin
        if (i_rst_dram_ctrl) begin
            o_write_seen <= 1'b0;
        end else if (i_write_last) begin
            o_write_seen <= 1'b1;
        end
    end

    // sticky flag only clears through reset
    a_write_seen_sticky : assert property (
        @(posedge i_clk_dram_ctrl) disable iff (i_rst_dram_ctrl)
        o_write_seen |=> o_write_seen
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# compile and run the testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module tb_dram_status_display \
    -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "=== PASS ===" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

// ==== seven_seg_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ctrl_consts.svh"

module seven_seg_scanner #(
    parameter int SCAN_CYCLES = 1024 // clocks each digit stays lit
) (
    input  logic                     i_clk_dram_ctrl,
    input  logic                     i_rst_dram_ctrl,
    input  display_pkg::disp_word_t  i_disp_word,
    output display_pkg::seg_t        o_cathode,
    output logic [`CTRL_DIGITS-1:0]  o_anode
);

    localparam int CNT_W = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;
    localparam int IDX_W = $clog2(`CTRL_DIGITS);
    localparam logic [CNT_W-1:0] REFRESH_LAST = CNT_W'(SCAN_CYCLES - 1);
    localparam logic [IDX_W-1:0] DIGIT_LAST   = IDX_W'(`CTRL_DIGITS - 1);

    logic [CNT_W-1:0]  refresh_cnt;
    logic [IDX_W-1:0]  digit_idx;
    logic [3:0]        nibble;

    // hex to segments, lit segment is a 0
    function automatic display_pkg::seg_t hex_to_seg(input logic [3:0] hex);
        logic [6:0] lit; // gfedcba, active high
        case (hex)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C; // lower case b
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E; // lower case d
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    always_ff @(posedge i_clk_dram_ctrl) begin
        if (i_rst_dram_ctrl) begin
            refresh_cnt <= '0;
            digit_idx   <= '0;
        end else if (refresh_cnt == REFRESH_LAST) begin
            refresh_cnt <= '0;
            digit_idx   <= (digit_idx == DIGIT_LAST) ? '0 : digit_idx + 1'b1;
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
        end
    end

    assign nibble = i_disp_word.raw[{digit_idx, 2'b00} +: 4];

    // anode and cathode leave together so the digit never shows a stale nibble
    always_ff @(posedge i_clk_dram_ctrl) begin
        if (i_rst_dram_ctrl) begin
            o_anode   <= '1; // blank
            o_cathode <= '1;
        end else begin
            o_anode   <= ~(`CTRL_DIGITS'(1) << digit_idx);
            o_cathode <= hex_to_seg(nibble);
        end
    end

    a_one_digit_lit : assert property (
        @(posedge i_clk_dram_ctrl) disable iff (i_rst_dram_ctrl)
        $onehot0(~o_anode)
    );

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
knob_pkg.sv
display_pkg.sv
knob_sync.sv
mem_activity_monitor.sv
display_page_mux.sv
seven_seg_scanner.sv
dram_status_display.sv
tb_dram_status_display.sv

// ==== tb_display_tasks.svh ====
`ifndef TB_DISPLAY_TASKS_SVH
`define TB_DISPLAY_TASKS_SVH

// active-low pattern back to hex, bit 4 set when the pattern is known
function automatic logic [4:0] seg_to_nibble(input display_pkg::seg_t seg);
    case (seg)
        7'h40: return 5'h10;
        7'h79: return 5'h11;
        7'h24: return 5'h12;
        7'h30: return 5'h13;
        7'h19: return 5'h14;
        7'h12: return 5'h15;
        7'h02: return 5'h16;
        7'h78: return 5'h17;
        7'h00: return 5'h18;
        7'h10: return 5'h19;
        7'h08: return 5'h1A;
        7'h03: return 5'h1B; // b
        7'h46: return 5'h1C;
        7'h21: return 5'h1D; // d
        7'h06: return 5'h1E;
        7'h0E: return 5'h1F;
        default: return 5'h00;
    endcase
endfunction

// rebuilds the shown word from one full scan, digit 0 first
task automatic read_display(input string test_name, output logic [31:0] word);
    logic [`CTRL_DIGITS-1:0] target;
    logic [`CTRL_DIGITS-1:0] prev;
    logic [4:0]              decoded;
    word = '0;
    prev = '1;
    @(negedge clk_dram_ctrl);
    while (seg_anode === ~`CTRL_DIGITS'(1)) begin // start on a fresh digit 0
        @(negedge clk_dram_ctrl);
    end
    for (int k = 0; k < `CTRL_DIGITS; k++) begin
        target = ~(`CTRL_DIGITS'(1) << k);
        while (seg_anode !== target) begin
            check_eq({test_name, " one anode low"}, 32'd1, 32'($countones(~seg_anode)));
            if (k > 0) begin
                check_eq({test_name, " digit order"}, 32'(prev), 32'(seg_anode));
            end
            @(negedge clk_dram_ctrl);
        end
        @(negedge clk_dram_ctrl);
        check_eq({test_name, " digit held"}, 32'(target), 32'(seg_anode));
        decoded = seg_to_nibble(seg_cathode);
        if (!decoded[4]) begin
            stop_on_error($sformatf("unknown segment pattern %b on digit %0d in %s",
                                    seg_cathode, k, test_name));
        end
        word[4*k +: 4] = decoded[3:0];
        prev = target;
    end
endtask

task automatic test_reset_state();
    logic [31:0] shown;
    apply_reset();
    wait_cycles(4);
    check_eq("reset_state write_seen", 32'd0, 32'(write_seen));
    read_display("reset_state", shown);
    check_eq("reset_state page 0", 32'd0, shown);
endtask

task automatic test_knob_pages();
    logic [127:0]            bits;
    logic [`CTRL_KNOB_W-1:0] upper;
    logic [`CTRL_KNOB_W-1:0] lower;
    logic [31:0]             shown;
    bits  = {$urandom(), $urandom(), $urandom(), $urandom()};
    knobs = knob_pkg::knob_bundle_t'(bits[119:0]);
    for (int p = 1; p <= 6; p++) begin
        case (p)
            1: {upper, lower} = {knobs.volume, knobs.pitch};
            2: {upper, lower} = {knobs.delay_wet, knobs.delay_rate};
            3: {upper, lower} = {knobs.delay_feedback, knobs.reverb_wet};
            4: {upper, lower} = {knobs.reverb_size, knobs.reverb_feedback};
            5: {upper, lower} = {knobs.filter_quality, knobs.filter_cutoff};
            default: {upper, lower} = {knobs.distortion_drive, knobs.crush_pressure};
        endcase
        page = display_pkg::page_t'(p);
        wait_cycles(4);
        read_display($sformatf("knob_page %0d", p), shown);
        check_eq($sformatf("knob_page %0d", p), {16'(upper), 16'(lower)}, shown);
    end
endtask

task automatic test_routing_page();
    logic [31:0] bits;
    logic [31:0] shown;
    bits  = $urandom();
    route = knob_pkg::patch_route_t'(bits[17:0]);
    page  = display_pkg::PAGE_ROUTING;
    wait_cycles(4);
    read_display("routing_page", shown);
    // one source per hex digit, output on digit 0, delay on digit 5
    check_eq("routing_page", {8'h00, 4'(route.delay_src), 4'(route.reverb_src),
             4'(route.filter_src), 4'(route.distortion_src), 4'(route.crush_src),
             4'(route.output_src)}, shown);
endtask

task automatic test_completion_count();
    int          pulses;
    logic [31:0] shown;
    pulses = $urandom_range(300, 1);
    for (int i = 0; i < pulses; i++) begin
        mem_complete = 1'b1;
        @(negedge clk_dram_ctrl);
        mem_complete = 1'b0;
        sent_completions++;
        wait_cycles($urandom_range(3, 0)); // gap of 0 gives back to back pulses
    end
    page = display_pkg::PAGE_COUNT;
    wait_cycles(4);
    read_display("completion_count", shown);
    check_eq("completion_count", {16'h0000, 16'(sent_completions)}, shown);
endtask

task automatic test_write_flag();
    for (int i = 0; i < 10; i++) begin
        check_eq("write_flag before pulse", 32'd0, 32'(write_seen));
        @(negedge clk_dram_ctrl);
    end
    write_last = 1'b1;
    @(negedge clk_dram_ctrl);
    write_last = 1'b0;
    check_eq("write_flag one cycle on", 32'd1, 32'(write_seen));
    for (int i = 0; i < 20; i++) begin
        @(negedge clk_dram_ctrl);
        check_eq("write_flag held", 32'd1, 32'(write_seen));
    end
    apply_reset();
    check_eq("write_flag after reset", 32'd0, 32'(write_seen));
endtask

`endif

// ==== tb_dram_status_display.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ctrl_consts.svh"

module tb_dram_status_display;

    localparam int SCAN_CYCLES = 4;
    localparam int CLK_HALF    = 4; // 8 ns period
    // one readback takes about 3 * 8 * SCAN_CYCLES cycles, ten of them
    // plus up to 300 pulses with gaps of 3 come to about 3000
    localparam int TIMEOUT_CYCLES = 20000;

    logic                    clk_dram_ctrl = 1'b0;
    logic                    rst_dram_ctrl;
    knob_pkg::knob_bundle_t  knobs;
    knob_pkg::patch_route_t  route;
    display_pkg::page_t      page;
    logic                    mem_complete;
    logic                    write_last;
    display_pkg::seg_t       seg_cathode;
    logic [`CTRL_DIGITS-1:0] seg_anode;
    logic                    write_seen;

    int cycle_count = 0;
    int sent_completions; // pulses since the last reset

    dram_status_display #(
        .SCAN_CYCLES (SCAN_CYCLES)
    ) dram_status_display_i (
        .i_clk_dram_ctrl (clk_dram_ctrl),
        .i_rst_dram_ctrl (rst_dram_ctrl),
        .i_knobs         (knobs),
        .i_route         (route),
        .i_page          (page),
        .i_mem_complete  (mem_complete),
        .i_write_last    (write_last),
        .o_seg_cathode   (seg_cathode),
        .o_seg_anode     (seg_anode),
        .o_write_seen    (write_seen)
    );

    initial begin
        forever #CLK_HALF clk_dram_ctrl = ~clk_dram_ctrl;
    end

    always @(posedge clk_dram_ctrl) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_eq(
        input string       test_name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (actual !== expected) begin
            $display("FAILED %s: expected 0x%08h, actual 0x%08h", test_name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "mismatch in %s", test_name);
        end
    endtask

    task automatic stop_on_error(input string what);
        $display("ERROR: %s", what);
        $display("=== FAIL ===");
        $fatal(1, "run stopped on error");
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk_dram_ctrl);
    endtask

    // two rising edges with reset high, released on a falling edge
    task automatic apply_reset();
        rst_dram_ctrl = 1'b1;
        repeat (2) @(negedge clk_dram_ctrl);
        rst_dram_ctrl    = 1'b0;
        sent_completions = 0;
    endtask

    `include "tb_display_tasks.svh"

    initial begin
        void'($urandom(82));
        rst_dram_ctrl    = 1'b1;
        knobs            = '0;
        route            = '0;
        page             = display_pkg::PAGE_COUNT;
        mem_complete     = 1'b0;
        write_last       = 1'b0;
        sent_completions = 0;

        test_reset_state();
        test_knob_pages();
        test_routing_page();
        test_completion_count();
        test_write_flag();

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
